/* compile.f */
+incdir+bench
common/trace_pkg.sv
trace_decode/trace_decoder.sv
logic/event_fifo.sv
logic/event_merger.sv
logic/termination_tracker.sv
logic/trace_monitor_top.sv
bench/tb_trace_monitor.sv

/* bench/tb_vectors.svh */
// Stimulus table and xorshift source for the trace monitor testbench; included inside the bench module
`ifndef TB_VECTORS_SVH
`define TB_VECTORS_SVH

// What one core retires in a table row
typedef enum logic [1:0] {REC_IDLE, REC_WR_R3, REC_WR_OTHER, REC_SPECIAL} rec_kind_e;

typedef struct packed {
   rec_kind_e   kind;
   logic [15:0] code;
   logic [31:0] data;
} core_step_t;

// One row, plus the done level expected while it is driven
typedef struct packed {
   core_step_t [NUM_CORES-1:0] step;
   logic                       exp_done;
} vec_row_t;

vec_row_t    vectors [$];
logic [31:0] rng_state = 32'h065c_1cf3;

function automatic logic [31:0] xorshift32(input logic [31:0] s);
   logic [31:0] x;
   x = s ^ (s << 13);
   x = x ^ (x >> 17);
   return x ^ (x << 5);
endfunction

function automatic logic [31:0] next_random();
   rng_state = xorshift32(rng_state);
   return rng_state;
endfunction

task automatic add_row(input rec_kind_e k0, input logic [15:0] c0, input logic [31:0] d0,
                       input rec_kind_e k1, input logic [15:0] c1, input logic [31:0] d1,
                       input logic done);
   vec_row_t row;
   row.step[0]  = {k0, c0, d0};
   row.step[1]  = {k1, c1, d1};
   row.exp_done = done;
   vectors.push_back(row);
endtask

// Writes to r5 with random data, r3 untouched
task automatic add_fillers(input int n, input logic done);
   for (int i = 0; i < n; i++) begin
      add_row(REC_WR_OTHER, NOP_NOP, next_random(), REC_WR_OTHER, NOP_NOP, next_random(), done);
   end
endtask

task automatic load_vectors();
   // putc takes low byte of the last r3 write
   add_row(REC_WR_R3,    NOP_NOP,    32'h0000_0141, REC_IDLE,     NOP_NOP,    32'h0, 1'b0);
   add_row(REC_WR_OTHER, NOP_NOP,    32'h0000_0077, REC_IDLE,     NOP_NOP,    32'h0, 1'b0);
   add_row(REC_SPECIAL,  NOP_PUTC,   32'h0,         REC_IDLE,     NOP_NOP,    32'h0, 1'b0);
   add_row(REC_WR_R3,    NOP_NOP,    32'h1234_5642, REC_WR_OTHER, NOP_NOP,    32'hdead_beef, 1'b0);
   add_row(REC_SPECIAL,  NOP_PUTC,   32'h0,         REC_IDLE,     NOP_NOP,    32'h0, 1'b0);
   // report carries full r3, code 0 is silent
   add_row(REC_WR_R3,    NOP_NOP,    32'hcafe_0123, REC_WR_R3,    NOP_NOP,    32'h0bad_f00d, 1'b0);
   add_row(REC_SPECIAL,  NOP_REPORT, 32'h0,         REC_SPECIAL,  NOP_NOP,    32'h0, 1'b0);
   add_row(REC_SPECIAL,  NOP_NOP,    32'h0,         REC_SPECIAL,  NOP_REPORT, 32'h0, 1'b0);
   // Both cores at once
   add_row(REC_SPECIAL,  NOP_PUTC,   32'h0,         REC_SPECIAL,  NOP_PUTC,   32'h0, 1'b0);
   add_row(REC_WR_R3,    NOP_NOP,    32'h0000_0055, REC_WR_R3,    NOP_NOP,    32'h0000_0066, 1'b0);
   add_row(REC_SPECIAL,  NOP_REPORT, 32'h0,         REC_SPECIAL,  NOP_REPORT, 32'h0, 1'b0);
   add_row(REC_SPECIAL,  NOP_PUTC,   32'h0,         REC_SPECIAL,  NOP_PUTC,   32'h0, 1'b0);
   add_fillers(8, 1'b0);
   // Burst longer than one pop every other cycle can absorb
   add_row(REC_WR_R3,    NOP_NOP,    32'ha5a5_0011, REC_WR_R3,    NOP_NOP,    32'h5a5a_0022, 1'b0);
   for (int i = 0; i < 8; i++) begin
      add_row(REC_SPECIAL, i[0] ? NOP_PUTC : NOP_REPORT, 32'h0,
              REC_SPECIAL, i[0] ? NOP_REPORT : NOP_PUTC, 32'h0, 1'b0);
   end
   add_fillers(12, 1'b0);
   // Core 0 exits alone, then core 1, then core 0 again
   add_row(REC_WR_R3,    NOP_NOP,    32'h0000_0007, REC_WR_R3,    NOP_NOP,    32'h0000_0009, 1'b0);
   add_row(REC_SPECIAL,  NOP_EXIT,   32'h0,         REC_IDLE,     NOP_NOP,    32'h0, 1'b0);
   add_fillers(3, 1'b0);
   add_row(REC_WR_R3,    NOP_NOP,    32'h0000_00ff, REC_IDLE,     NOP_NOP,    32'h0, 1'b0);
   add_row(REC_SPECIAL,  NOP_EXIT,   32'h0,         REC_SPECIAL,  NOP_EXIT,   32'h0, 1'b0);
   add_row(REC_IDLE,     NOP_NOP,    32'h0,         REC_IDLE,     NOP_NOP,    32'h0, 1'b0);
   add_row(REC_IDLE,     NOP_NOP,    32'h0,         REC_IDLE,     NOP_NOP,    32'h0, 1'b1);
   add_fillers(6, 1'b1);
endtask

`endif

/* bench/tb_trace_monitor.sv */
// Trace monitor testbench; applies the vector table and checks against a reference model
`timescale 1ns/100ps

module tb_trace_monitor import trace_pkg::*; ();

   localparam int NUM_CORES  = 2;
   localparam int FIFO_DEPTH = 4;

   logic                             clk, rst;
   trace_rec_t [NUM_CORES-1:0]       trace;
   event_t                           evt;
   logic                             overflow, done;
   logic [NUM_CORES-1:0]             exited;
   logic [NUM_CORES-1:0][DATA_W-1:0] exit_code;

   // Reference model state
   logic [DATA_W-1:0] shadow_r3 [NUM_CORES];
   event_t            pending [NUM_CORES];
   int                fill [NUM_CORES];
   int                last_grant;
   logic              exp_overflow;
   logic [NUM_CORES-1:0] exit_seen;
   logic [DATA_W-1:0] exp_code [NUM_CORES];
   event_t            expected [$];
   int                cycle_count, cycle_limit;

   `include "tb_vectors.svh"

   trace_monitor_top #(
      .NUM_CORES  (NUM_CORES),
      .FIFO_DEPTH (FIFO_DEPTH)
   ) i_trace_monitor_top (
      .clk_i       (clk),
      .rst_i       (rst),
      .trace_i     (trace),
      .evt_o       (evt),
      .overflow_o  (overflow),
      .exited_o    (exited),
      .exit_code_o (exit_code),
      .done_o      (done)
   );

   initial begin
      clk = 1'b0;
      forever #20 clk = ~clk;
   end

   task automatic stop_run();
      $display("TEST FAILED");
      $fatal(1, "Simulation stopped at first error");
   endtask

   task automatic fail_value(input string name, input logic [31:0] exp, input logic [31:0] got);
      $display("FAILED %s exp=%h got=%h", name, exp, got);
      stop_run();
   endtask

   task automatic fail_text(input string msg);
      $display("%s", msg);
      stop_run();
   endtask

   always @(posedge clk) begin
      if (rst) begin
         cycle_count <= 0;
      end else begin
         cycle_count <= cycle_count + 1;
         if (cycle_count >= cycle_limit) fail_text("Run did not finish within the cycle limit");
      end
   end

   function automatic trace_rec_t make_record(input core_step_t s);
      trace_rec_t  r;
      logic [31:0] junk;
      junk     = next_random();
      r.valid  = 1'b1;
      r.pc     = next_random();
      r.insn   = {8'he0, junk[23:0]};
      r.wben   = 1'b1;
      r.wbreg  = R3_INDEX;
      r.wbdata = s.data;
      case (s.kind)
         // Invalid record with r3 junk, must be ignored
         REC_IDLE: begin
            r.valid  = 1'b0;
            r.wbdata = junk;
         end
         REC_WR_R3:    r.wbreg = R3_INDEX;
         REC_WR_OTHER: r.wbreg = 5'd5;
         default: begin
            r.insn = {NOP_OPCODE, 8'h00, s.code};
            r.wben = 1'b0;
         end
      endcase
      return r;
   endfunction

   // Queue fill and round-robin pop for one clock edge
   task automatic step_model();
      int g;
      int k;
      g = -1;
      for (int i = 1; i <= NUM_CORES; i++) begin
         k = (last_grant + i) % NUM_CORES;
         if (g < 0 && fill[k] > 0) g = k;
      end
      if (g >= 0) last_grant = g;
      for (int c = 0; c < NUM_CORES; c++) begin
         if (pending[c].valid) begin
            // Full before the edge means dropped, even with a pop
            if (fill[c] == FIFO_DEPTH) begin
               exp_overflow = 1'b1;
            end else begin
               expected.push_back(pending[c]);
               fill[c]++;
            end
         end
         if (c == g) fill[c]--;
      end
   endtask

   task automatic decode_record(input int k, input trace_rec_t rec);
      event_t ev;
      ev = '0;
      if (rec.valid && rec.insn[31:24] == NOP_OPCODE) begin
         ev.valid = 1'b1;
         ev.value = shadow_r3[k];
         case (rec.insn[15:0])
            NOP_EXIT:   ev.kind = EV_EXIT;
            NOP_REPORT: ev.kind = EV_REPORT;
            NOP_PUTC: begin
               ev.kind  = EV_PUTC;
               ev.value = {24'h0, shadow_r3[k][7:0]};
            end
            default:    ev.valid = 1'b0;
         endcase
         if (ev.valid && ev.kind == EV_EXIT && !exit_seen[k]) begin
            exit_seen[k] = 1'b1;
            exp_code[k]  = shadow_r3[k];
         end
      end
      ev.core    = CORE_ID_W'(k);
      pending[k] = ev;
      if (rec.valid && rec.wben && rec.wbreg == R3_INDEX) shadow_r3[k] = rec.wbdata;
   endtask

   task automatic apply_row(input vec_row_t row);
      for (int k = 0; k < NUM_CORES; k++) trace[k] = make_record(row.step[k]);
      step_model();
      for (int k = 0; k < NUM_CORES; k++) decode_record(k, trace[k]);
   endtask

   task automatic check_outputs(input logic exp_done);
      int     idx;
      event_t exp_evt;
      assert (overflow == exp_overflow) else fail_value("overflow_o", exp_overflow, overflow);
      assert (done == exp_done) else fail_value("done_o", exp_done, done);
      if (evt.valid) begin
         assert (evt.core < NUM_CORES)
            else fail_text("evt_o.core names a core that does not exist");
         // Oldest expected event of that core
         idx = -1;
         foreach (expected[i]) begin
            if (idx < 0 && expected[i].core == evt.core) idx = i;
         end
         assert (idx >= 0)
            else fail_text("evt_o carried an event no record of that core produced");
         exp_evt = expected[idx];
         expected.delete(idx);
         assert (evt.kind == exp_evt.kind) else fail_value("evt_o.kind", exp_evt.kind, evt.kind);
         assert (evt.value == exp_evt.value)
            else fail_value("evt_o.value", exp_evt.value, evt.value);
      end
   endtask

   initial begin
      vec_row_t idle_row;
      rst   = 1'b1;
      trace = '0;
      for (int k = 0; k < NUM_CORES; k++) begin
         shadow_r3[k] = '0;
         pending[k]   = '0;
         fill[k]      = 0;
         exp_code[k]  = '0;
      end
      // Core 0 is granted first after reset
      last_grant   = NUM_CORES - 1;
      exp_overflow = 1'b0;
      exit_seen    = '0;
      idle_row     = '0;
      load_vectors();
      cycle_limit  = vectors.size() + 50;
      repeat (8) @(negedge clk);
      rst = 1'b0;
      foreach (vectors[i]) begin
         check_outputs(vectors[i].exp_done);
         apply_row(vectors[i]);
         @(negedge clk);
      end
      // Drain, then a few quiet cycles
      while (expected.size() != 0) begin
         check_outputs(1'b1);
         apply_row(idle_row);
         @(negedge clk);
      end
      repeat (3) begin
         check_outputs(1'b1);
         apply_row(idle_row);
         @(negedge clk);
      end
      assert (exited == exit_seen) else fail_value("exited_o", exit_seen, exited);
      for (int k = 0; k < NUM_CORES; k++) begin
         assert (exit_code[k] == exp_code[k])
            else fail_value("exit_code_o", exp_code[k], exit_code[k]);
      end
      $display("TEST PASSED");
      $finish;
   end

endmodule

/* logic/trace_monitor_top.sv */
// Trace monitor top: per-core decoders feeding the event merger and the termination tracker
`timescale 1ns/100ps

module trace_monitor_top import trace_pkg::*; #(
   parameter int NUM_CORES  = 2,
   parameter int FIFO_DEPTH = 4
) (
   input  logic                                   clk_i,
   input  logic                                   rst_i,
   // One trace record per core per cycle
   input  trace_rec_t [NUM_CORES-1:0]             trace_i,
   // Merged event stream
   output event_t                                 evt_o,
   output logic                                   overflow_o,
   // Termination status
   output logic       [NUM_CORES-1:0]             exited_o,
   output logic       [NUM_CORES-1:0][DATA_W-1:0] exit_code_o,
   output logic                                   done_o
);

   // Decoded event strobes, one per core
   event_t [NUM_CORES-1:0] evt;

   for (genvar k = 0; k < NUM_CORES; k++) begin : g_core
      trace_decoder i_trace_decoder (
         .clk_i (clk_i),
         .rst_i (rst_i),
         .rec_i (trace_i[k]),
         .evt_o (evt[k])
      );
   end

   // Queues and round-robin merge
   event_merger #(
      .NUM_CORES  (NUM_CORES),
      .FIFO_DEPTH (FIFO_DEPTH)
   ) i_event_merger (
      .clk_i      (clk_i),
      .rst_i      (rst_i),
      .evt_i      (evt),
      .evt_o      (evt_o),
      .overflow_o (overflow_o)
   );

   // Watches the same strobes, unaffected by queue drops
   termination_tracker #(
      .NUM_CORES (NUM_CORES)
   ) i_termination_tracker (
      .clk_i       (clk_i),
      .rst_i       (rst_i),
      .evt_i       (evt),
      .exited_o    (exited_o),
      .exit_code_o (exit_code_o),
      .done_o      (done_o)
   );

endmodule

/* logic/termination_tracker.sv */
// Records each core's first exit and its code; raises done once every core has exited
`timescale 1ns/100ps

module termination_tracker import trace_pkg::*; #(
   parameter int NUM_CORES = 2
) (
   input  logic                               clk_i,
   input  logic                               rst_i,
   input  event_t [NUM_CORES-1:0]             evt_i,
   output logic   [NUM_CORES-1:0]             exited_o,
   output logic   [NUM_CORES-1:0][DATA_W-1:0] exit_code_o,
   output logic                               done_o
);

   logic [NUM_CORES-1:0]             exited_q, exited_d;
   logic [NUM_CORES-1:0]             first_exit;
   logic [NUM_CORES-1:0][DATA_W-1:0] code_q;
   logic                             done_q;

   // Only the first exit of a core counts
   always_comb begin
      for (int k = 0; k < NUM_CORES; k++) begin
         first_exit[k] = evt_i[k].valid && (evt_i[k].kind == EV_EXIT) && !exited_q[k];
      end
   end

   assign exited_d = exited_q | first_exit;

   always_ff @(posedge clk_i) begin
      if (rst_i) begin
         exited_q <= '0;
         done_q   <= 1'b0;
      end else begin
         exited_q <= exited_d;
         // Same edge as the last exited bit
         done_q   <= &exited_d;
      end
   end

   // Exit code is r3 at the exit instruction
   always_ff @(posedge clk_i) begin
      for (int k = 0; k < NUM_CORES; k++) begin
         if (first_exit[k]) code_q[k] <= evt_i[k].value;
      end
   end

   assign exited_o    = exited_q;
   assign exit_code_o = code_q;
   assign done_o      = done_q;

endmodule

/* logic/event_merger.sv */
// Per-core event queues merged round-robin into one registered event stream
`timescale 1ns/100ps

module event_merger import trace_pkg::*; #(
   parameter int NUM_CORES  = 2,
   parameter int FIFO_DEPTH = 4
) (
   input  logic                   clk_i,
   input  logic                   rst_i,
   input  event_t [NUM_CORES-1:0] evt_i,
   output event_t                 evt_o,
   output logic                   overflow_o
);

   // Queue side
   event_t [NUM_CORES-1:0] q_head;
   logic   [NUM_CORES-1:0] q_nonempty;
   logic   [NUM_CORES-1:0] q_pop;
   logic   [NUM_CORES-1:0] q_overflow;

   // Arbiter
   logic [CORE_ID_W-1:0] last_grant;
   logic [CORE_ID_W-1:0] grant_idx;
   logic                 grant_valid;

   // Output register
   logic                 out_valid_q;
   event_kind_e          out_kind_q;
   logic [CORE_ID_W-1:0] out_core_q;
   logic [DATA_W-1:0]    out_value_q;

   for (genvar k = 0; k < NUM_CORES; k++) begin : g_fifo
      event_fifo #(
         .FIFO_DEPTH (FIFO_DEPTH)
      ) i_event_fifo (
         .clk_i      (clk_i),
         .rst_i      (rst_i),
         .wr_i       (evt_i[k]),
         .pop_i      (q_pop[k]),
         .head_o     (q_head[k]),
         .nonempty_o (q_nonempty[k]),
         .overflow_o (q_overflow[k])
      );

      // Pop only the granted queue
      assign q_pop[k] = grant_valid && (grant_idx == CORE_ID_W'(k));
   end

   // First non-empty queue after the last grant
   always_comb begin
      int cand;
      grant_valid = 1'b0;
      grant_idx   = last_grant;
      for (int i = 1; i <= NUM_CORES; i++) begin
         cand = (int'(last_grant) + i) % NUM_CORES;
         if (!grant_valid && q_nonempty[cand]) begin
            grant_valid = 1'b1;
            grant_idx   = CORE_ID_W'(cand);
         end
      end
   end

   // Start so that core 0 wins first
   always_ff @(posedge clk_i) begin
      if (rst_i) begin
         last_grant  <= CORE_ID_W'(NUM_CORES - 1);
         out_valid_q <= 1'b0;
      end else begin
         if (grant_valid) last_grant <= grant_idx;
         out_valid_q <= grant_valid;
      end
   end

   // Granted head, core taken from the grant
   always_ff @(posedge clk_i) begin
      out_kind_q  <= q_head[grant_idx].kind;
      out_core_q  <= grant_idx;
      out_value_q <= q_head[grant_idx].value;
   end

   assign evt_o.valid = out_valid_q;
   assign evt_o.kind  = out_kind_q;
   assign evt_o.core  = out_core_q;
   assign evt_o.value = out_value_q;

   // Any queue lost an event
   assign overflow_o = |q_overflow;

endmodule

/* logic/event_fifo.sv */
// Small circular event queue per core, drops writes when full and flags overflow until reset
`timescale 1ns/100ps

module event_fifo import trace_pkg::*; #(
   parameter int FIFO_DEPTH = 4
) (
   input  logic   clk_i,
   input  logic   rst_i,
   input  event_t wr_i,
   input  logic   pop_i,
   output event_t head_o,
   output logic   nonempty_o,
   output logic   overflow_o
);

   localparam int PTR_W = (FIFO_DEPTH > 1) ? $clog2(FIFO_DEPTH) : 1;
   localparam int CNT_W = $clog2(FIFO_DEPTH + 1);

   // Storage
   event_t mem [FIFO_DEPTH];

   logic [PTR_W-1:0] rd_ptr, wr_ptr;
   logic [CNT_W-1:0] count;
   logic             full, do_wr, do_rd;
   logic             overflow_q;

   // Wrap at FIFO_DEPTH, not only at powers of two
   function automatic logic [PTR_W-1:0] ptr_inc(input logic [PTR_W-1:0] p);
      return (p == PTR_W'(FIFO_DEPTH - 1)) ? '0 : p + 1'b1;
   endfunction

   assign full       = (count == CNT_W'(FIFO_DEPTH));
   assign nonempty_o = (count != '0);
   // Write to a full queue is lost
   assign do_wr      = wr_i.valid && !full;
   assign do_rd      = pop_i && nonempty_o;

   always_ff @(posedge clk_i) begin
      if (rst_i) begin
         rd_ptr     <= '0;
         wr_ptr     <= '0;
         count      <= '0;
         overflow_q <= 1'b0;
      end else begin
         if (do_wr) wr_ptr <= ptr_inc(wr_ptr);
         if (do_rd) rd_ptr <= ptr_inc(rd_ptr);
         case ({do_wr, do_rd})
            2'b10:   count <= count + 1'b1;
            2'b01:   count <= count - 1'b1;
            default: count <= count;
         endcase
         // Sticky
         if (wr_i.valid && full) overflow_q <= 1'b1;
      end
   end

   always_ff @(posedge clk_i) begin
      if (do_wr) mem[wr_ptr] <= wr_i;
   end

   // Head valid only while something is queued
   always_comb begin
      head_o       = mem[rd_ptr];
      head_o.valid = nonempty_o;
   end

   assign overflow_o = overflow_q;

endmodule

/* trace_decode/trace_decoder.sv */
// Per-core decoder: tracks r3 and turns simulator no-operation instructions into event strobes
`timescale 1ns/100ps

module trace_decoder import trace_pkg::*; (
   input  logic       clk_i,
   input  logic       rst_i,
   input  trace_rec_t rec_i,
   output event_t     evt_o
);

   // Shadow copy of r3
   logic [DATA_W-1:0] r3_q;

   // Decode of the current record
   logic              is_nop;
   nop_code_e         nop_code;
   logic              evt_hit;
   event_kind_e       evt_kind;
   logic [DATA_W-1:0] evt_value;

   // Registered event
   logic              evt_valid_q;
   event_kind_e       evt_kind_q;
   logic [DATA_W-1:0] evt_value_q;

   // l.nop with major opcode 0x15
   assign is_nop = rec_i.valid &&
                   (rec_i.insn[DATA_W-1 -: 8] == NOP_OPCODE);

   // Immediate holds the simulator code
   assign nop_code = nop_code_e'(rec_i.insn[NOP_CODE_W-1:0]);

   always_comb begin
      evt_hit   = 1'b0;
      evt_kind  = EV_REPORT;
      evt_value = r3_q;
      if (is_nop) begin
         case (nop_code)
            NOP_EXIT: begin
               evt_hit  = 1'b1;
               evt_kind = EV_EXIT;
            end
            NOP_REPORT: begin
               evt_hit  = 1'b1;
               evt_kind = EV_REPORT;
            end
            NOP_PUTC: begin
               evt_hit   = 1'b1;
               evt_kind  = EV_PUTC;
               // Character is the low byte only
               evt_value = {{(DATA_W-8){1'b0}}, r3_q[7:0]};
            end
            // Plain nop, nothing to report
            NOP_NOP: evt_hit = 1'b0;
            default: evt_hit = 1'b0;
         endcase
      end
   end

   // r3 follows write-back, visible to the next record
   always_ff @(posedge clk_i) begin
      if (rst_i) begin
         r3_q <= '0;
      end else if (rec_i.valid && rec_i.wben && (rec_i.wbreg == R3_INDEX)) begin
         r3_q <= rec_i.wbdata;
      end
   end

   // Event strobe
   always_ff @(posedge clk_i) begin
      if (rst_i) begin
         evt_valid_q <= 1'b0;
      end else begin
         evt_valid_q <= evt_hit;
      end
   end

   // Event payload
   always_ff @(posedge clk_i) begin
      evt_kind_q  <= evt_kind;
      evt_value_q <= evt_value;
   end

   // Core index stamped later by the merger
   assign evt_o.valid = evt_valid_q;
   assign evt_o.kind  = evt_kind_q;
   assign evt_o.core  = '0;
   assign evt_o.value = evt_value_q;

endmodule

/* common/trace_pkg.sv */
// Shared trace record, event record and encoding constants; imported by every monitor module
package trace_pkg;

   // Datapath and register file widths
   localparam int DATA_W     = 32;
   localparam int REG_ADDR_W = 5;

   // Immediate field of l.nop, insn bits 15..0
   localparam int NOP_CODE_W = 16;

   // Core index width, enough for 16 cores
   localparam int CORE_ID_W  = 4;

   // Major opcode in insn[31:24] marking a no-operation
   localparam logic [7:0] NOP_OPCODE = 8'h15;

   // Register whose value the simulator calls report
   localparam logic [REG_ADDR_W-1:0] R3_INDEX = 5'd3;

   // One retired instruction of one core
   typedef struct packed {
      logic                  valid;
      logic [DATA_W-1:0]     pc;
      logic [DATA_W-1:0]     insn;
      // Register write-back
      logic                  wben;
      logic [REG_ADDR_W-1:0] wbreg;
      logic [DATA_W-1:0]     wbdata;
   } trace_rec_t;

   // Special no-operation codes used by software to talk to the simulator
   typedef enum logic [NOP_CODE_W-1:0] {
      NOP_NOP    = 16'h0000,
      NOP_EXIT   = 16'h0001,
      NOP_REPORT = 16'h0002,
      NOP_PUTC   = 16'h0004
   } nop_code_e;

   // Kinds of decoded events
   typedef enum logic [1:0] {
      EV_PUTC   = 2'd0,
      EV_REPORT = 2'd1,
      EV_EXIT   = 2'd2
   } event_kind_e;

   // Decoded event, valid is a one-cycle strobe
   typedef struct packed {
      logic                 valid;
      event_kind_e          kind;
      // Source core, filled in by the merger
      logic [CORE_ID_W-1:0] core;
      // r3, or only its low byte for putc
      logic [DATA_W-1:0]    value;
   } event_t;

endpackage
